/* src/vga_pkg.sv */
package vga_pkg;

    // XGA 1024x768 at 65 MHz pixel clock
    localparam int H_ACTIVE = 1024;
    localparam int H_FP     = 24;
    localparam int H_SYNC   = 136;
    localparam int H_TOTAL  = 1344;

    localparam int V_ACTIVE = 768;
    localparam int V_FP     = 3;
    localparam int V_SYNC   = 6;
    localparam int V_TOTAL  = 806;

    // game modes as delivered by the game FSM
    typedef enum logic [2:0] {
        MENU_MODE    = 3'd0,
        GAME_MODE    = 3'd1,
        VICTORY_MODE = 3'd2,
        GAME_OVER    = 3'd3,
        MULTI_WAIT   = 3'd4
    } mode_t;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    localparam rgb_t C_BLACK     = 12'h000;
    localparam rgb_t C_WHITE     = 12'hfff;
    localparam rgb_t C_YELLOW    = 12'hff0;
    localparam rgb_t C_RED       = 12'hf00;
    localparam rgb_t C_GREEN     = 12'h0f0;
    localparam rgb_t C_BLUE      = 12'h00f;
    localparam rgb_t C_VICTORY   = 12'h2f2;
    localparam rgb_t C_GAME_OVER = 12'hf22;
    localparam rgb_t C_WAIT      = 12'h22f;
    localparam rgb_t C_MARKER    = 12'hfa0;

    // menu title bar, inclusive limits
    localparam int TITLE_X0 = 170;
    localparam int TITLE_X1 = 910;
    localparam int TITLE_Y0 = 90;
    localparam int TITLE_Y1 = 250;

    // player marker edge length in pixels
    localparam int MARKER_SIZE = 16;

endpackage

/* src/vga_if.sv */
`timescale 1ns/10ps

interface vga_if
    import vga_pkg::*;
();

    logic [11:0] hcount;
    logic [11:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;

    modport src (
        output hcount, vcount,
        output hsync, vsync,
        output hblnk, vblnk,
        output rgb
    );

    modport snk (
        input hcount, vcount,
        input hsync, vsync,
        input hblnk, vblnk,
        input rgb
    );

endinterface

/* src/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing
    import vga_pkg::*;
(
    input  logic clk,
    input  logic rst,
    vga_if.src   out
);

    localparam logic [11:0] H_LAST    = 12'(H_TOTAL - 1);
    localparam logic [11:0] V_LAST    = 12'(V_TOTAL - 1);
    localparam logic [11:0] H_BLANK   = 12'(H_ACTIVE);
    localparam logic [11:0] V_BLANK   = 12'(V_ACTIVE);
    localparam logic [11:0] HS_START  = 12'(H_ACTIVE + H_FP);
    localparam logic [11:0] HS_END    = 12'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [11:0] VS_START  = 12'(V_ACTIVE + V_FP);
    localparam logic [11:0] VS_END    = 12'(V_ACTIVE + V_FP + V_SYNC);

    logic [11:0] hcount_q;
    logic [11:0] vcount_q;
    logic [11:0] hcount_nxt;
    logic [11:0] vcount_nxt;
    logic        hsync_q;
    logic        vsync_q;
    logic        hblnk_q;
    logic        vblnk_q;

    // next raster position
    always_comb begin
        hcount_nxt = hcount_q + 12'd1;
        vcount_nxt = vcount_q;
        if (hcount_q == H_LAST) begin
            hcount_nxt = '0;
            if (vcount_q == V_LAST) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount_q + 12'd1;
            end
        end
    end

    // decode flags from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_q <= '0;
            vcount_q <= '0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            hblnk_q  <= 1'b0;
            vblnk_q  <= 1'b0;
        end else begin
            hcount_q <= hcount_nxt;
            vcount_q <= vcount_nxt;
            hblnk_q  <= (hcount_nxt >= H_BLANK);
            vblnk_q  <= (vcount_nxt >= V_BLANK);
            hsync_q  <= (hcount_nxt >= HS_START) && (hcount_nxt < HS_END);
            vsync_q  <= (vcount_nxt >= VS_START) && (vcount_nxt < VS_END);
        end
    end

    assign out.hcount = hcount_q;
    assign out.vcount = vcount_q;
    assign out.hsync  = hsync_q;
    assign out.vsync  = vsync_q;
    assign out.hblnk  = hblnk_q;
    assign out.vblnk  = vblnk_q;

    // the painters downstream supply all colour
    assign out.rgb    = C_BLACK;

endmodule

/* src/draw_background.sv */
`timescale 1ns/10ps

module draw_background
    import vga_pkg::*;
#(
    parameter int TOP_V_LINE    = 317,
    parameter int BOTTOM_V_LINE = 617,
    parameter int LEFT_H_LINE   = 361,
    parameter int RIGHT_H_LINE  = 661,
    parameter int BORDER        = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  mode_t control_state,
    vga_if.snk    in,
    vga_if.src    out
);

    localparam logic [11:0] H_EDGE_R = 12'(H_ACTIVE - 1);
    localparam logic [11:0] V_EDGE_B = 12'(V_ACTIVE - 1);

    // outer and inner bounds of the game frame, upper bounds exclusive
    localparam logic [11:0] FRAME_X0 = 12'(LEFT_H_LINE - BORDER);
    localparam logic [11:0] FRAME_X1 = 12'(RIGHT_H_LINE + BORDER);
    localparam logic [11:0] FRAME_Y0 = 12'(TOP_V_LINE - BORDER);
    localparam logic [11:0] FRAME_Y1 = 12'(BOTTOM_V_LINE + BORDER);
    localparam logic [11:0] FIELD_X0 = 12'(LEFT_H_LINE);
    localparam logic [11:0] FIELD_X1 = 12'(RIGHT_H_LINE);
    localparam logic [11:0] FIELD_Y0 = 12'(TOP_V_LINE);
    localparam logic [11:0] FIELD_Y1 = 12'(BOTTOM_V_LINE);

    logic in_title;
    logic in_outer;
    logic in_field;
    logic in_frame;
    logic blank;
    rgb_t edge_rgb;
    logic on_edge;
    rgb_t rgb_q;
    rgb_t rgb_nxt;

    assign blank = in.hblnk || in.vblnk;

    assign in_title = (in.hcount >= 12'(TITLE_X0)) && (in.hcount <= 12'(TITLE_X1)) &&
                      (in.vcount >= 12'(TITLE_Y0)) && (in.vcount <= 12'(TITLE_Y1));

    assign in_outer = (in.hcount >= FRAME_X0) && (in.hcount < FRAME_X1) &&
                      (in.vcount >= FRAME_Y0) && (in.vcount < FRAME_Y1);
    assign in_field = (in.hcount >= FIELD_X0) && (in.hcount < FIELD_X1) &&
                      (in.vcount >= FIELD_Y0) && (in.vcount < FIELD_Y1);
    // ring between the outer bound and the play field
    assign in_frame = in_outer && !in_field;

    // coloured screen edges, top and bottom win over the sides
    always_comb begin
        on_edge  = 1'b1;
        edge_rgb = C_BLACK;
        if (in.vcount == 12'd0) begin
            edge_rgb = C_YELLOW;
        end else if (in.vcount == V_EDGE_B) begin
            edge_rgb = C_RED;
        end else if (in.hcount == 12'd0) begin
            edge_rgb = C_GREEN;
        end else if (in.hcount == H_EDGE_R) begin
            edge_rgb = C_BLUE;
        end else begin
            on_edge = 1'b0;
        end
    end

    always_comb begin
        case (control_state)
            MENU_MODE: begin
                if (blank) begin
                    rgb_nxt = C_BLACK;
                end else if (on_edge) begin
                    rgb_nxt = edge_rgb;
                end else if (in_title) begin
                    rgb_nxt = C_WHITE;
                end else begin
                    rgb_nxt = C_BLACK;
                end
            end
            GAME_MODE: begin
                if (blank) begin
                    rgb_nxt = C_BLACK;
                end else if (on_edge) begin
                    rgb_nxt = edge_rgb;
                end else if (in_frame) begin
                    rgb_nxt = C_WHITE;
                end else begin
                    rgb_nxt = C_BLACK;
                end
            end
            // flat screens also cover blanking
            VICTORY_MODE: rgb_nxt = C_VICTORY;
            GAME_OVER:    rgb_nxt = C_GAME_OVER;
            MULTI_WAIT:   rgb_nxt = C_WAIT;
            // unknown code keeps the last pixel
            default:      rgb_nxt = rgb_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            rgb_q      <= C_BLACK;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            rgb_q      <= rgb_nxt;
        end
    end

    assign out.rgb = rgb_q;

endmodule

/* src/draw_marker.sv */
`timescale 1ns/10ps

module draw_marker
    import vga_pkg::*;
#(
    parameter int TOP_V_LINE    = 317,
    parameter int BOTTOM_V_LINE = 617,
    parameter int LEFT_H_LINE   = 361,
    parameter int RIGHT_H_LINE  = 661,
    parameter int BORDER        = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  mode_t       control_state,
    input  logic [11:0] marker_x,
    input  logic [11:0] marker_y,
    vga_if.snk          in,
    output logic [11:0] hcount,
    output logic [11:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk,
    output rgb_t        rgb
);

    // legal top-left corners keep the whole square in the field
    localparam logic [11:0] X_MIN = 12'(LEFT_H_LINE);
    localparam logic [11:0] X_MAX = 12'(RIGHT_H_LINE - MARKER_SIZE);
    localparam logic [11:0] Y_MIN = 12'(TOP_V_LINE);
    localparam logic [11:0] Y_MAX = 12'(BOTTOM_V_LINE - MARKER_SIZE);
    localparam logic [11:0] SIZE  = 12'(MARKER_SIZE);

    logic [11:0] pos_x;
    logic [11:0] pos_y;
    logic        in_square;
    logic        show;

    always_comb begin
        if (marker_x < X_MIN) begin
            pos_x = X_MIN;
        end else if (marker_x > X_MAX) begin
            pos_x = X_MAX;
        end else begin
            pos_x = marker_x;
        end
        if (marker_y < Y_MIN) begin
            pos_y = Y_MIN;
        end else if (marker_y > Y_MAX) begin
            pos_y = Y_MAX;
        end else begin
            pos_y = marker_y;
        end
    end

    assign in_square = (in.hcount >= pos_x) && (in.hcount < pos_x + SIZE) &&
                       (in.vcount >= pos_y) && (in.vcount < pos_y + SIZE);

    assign show = (control_state == GAME_MODE) && !in.hblnk && !in.vblnk && in_square;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= C_BLACK;
        end else begin
            hcount <= in.hcount;
            vcount <= in.vcount;
            hsync  <= in.hsync;
            vsync  <= in.vsync;
            hblnk  <= in.hblnk;
            vblnk  <= in.vblnk;
            rgb    <= show ? C_MARKER : in.rgb;
        end
    end

endmodule

/* src/vga_top.sv */
`timescale 1ns/10ps

module vga_top
    import vga_pkg::*;
#(
    parameter int TOP_V_LINE    = 317,
    parameter int BOTTOM_V_LINE = 617,
    parameter int LEFT_H_LINE   = 361,
    parameter int RIGHT_H_LINE  = 661,
    parameter int BORDER        = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  mode_t       control_state,
    input  logic [11:0] marker_x,
    input  logic [11:0] marker_y,
    output logic [11:0] hcount,
    output logic [11:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk,
    output rgb_t        rgb
);

    // raster from the generator, then after the background stage
    vga_if t_bus ();
    vga_if b_bus ();

    vga_timing i_vga_timing (
        .clk (clk),
        .rst (rst),
        .out (t_bus)
    );

    draw_background #(
        .TOP_V_LINE    (TOP_V_LINE),
        .BOTTOM_V_LINE (BOTTOM_V_LINE),
        .LEFT_H_LINE   (LEFT_H_LINE),
        .RIGHT_H_LINE  (RIGHT_H_LINE),
        .BORDER        (BORDER)
    ) i_draw_background (
        .clk           (clk),
        .rst           (rst),
        .control_state (control_state),
        .in            (t_bus),
        .out           (b_bus)
    );

    // marker sees the same mode one cycle later than the background
    draw_marker #(
        .TOP_V_LINE    (TOP_V_LINE),
        .BOTTOM_V_LINE (BOTTOM_V_LINE),
        .LEFT_H_LINE   (LEFT_H_LINE),
        .RIGHT_H_LINE  (RIGHT_H_LINE),
        .BORDER        (BORDER)
    ) i_draw_marker (
        .clk           (clk),
        .rst           (rst),
        .control_state (control_state),
        .marker_x      (marker_x),
        .marker_y      (marker_y),
        .in            (b_bus),
        .hcount        (hcount),
        .vcount        (vcount),
        .hsync         (hsync),
        .vsync         (vsync),
        .hblnk         (hblnk),
        .vblnk         (vblnk),
        .rgb           (rgb)
    );

endmodule

/* testbench/vga_top_chk.sv */
`timescale 1ns/10ps

module vga_top_chk
    import vga_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic [11:0] hcount,
    input logic        hsync,
    input logic        vsync,
    input logic        hblnk,
    input logic        vblnk
);

    localparam logic [11:0] H_LAST = 12'(H_TOTAL - 1);
    localparam logic [11:0] H_END  = 12'(H_TOTAL);

    // output repeats pixel 0 while the pipeline fills
    logic [2:0] settled;
    logic       hsync_bad = 1'b0;
    logic       vsync_bad = 1'b0;
    logic       range_bad = 1'b0;
    logic       step_bad  = 1'b0;
    logic       failed;

    always_ff @(posedge clk) begin
        if (rst) begin
            settled <= '0;
        end else begin
            settled <= {settled[1:0], 1'b1};
        end
    end

    assign failed = hsync_bad || vsync_bad || range_bad || step_bad;

    hsync_in_blank: assert property (@(posedge clk) disable iff (rst) hsync |-> hblnk)
        else begin
            $error("hsync high outside horizontal blanking");
            hsync_bad = 1'b1;
        end

    vsync_in_blank: assert property (@(posedge clk) disable iff (rst) vsync |-> vblnk)
        else begin
            $error("vsync high outside vertical blanking");
            vsync_bad = 1'b1;
        end

    hcount_range: assert property (@(posedge clk) disable iff (rst) hcount < H_END)
        else begin
            $error("hcount beyond the line length");
            range_bad = 1'b1;
        end

    // one step per pixel, or back to 0 after the last one
    hcount_step: assert property (@(posedge clk) disable iff (rst)
        settled[2] |-> (hcount == $past(hcount) + 12'd1) ||
                       (hcount == 12'd0 && $past(hcount) == H_LAST))
        else begin
            $error("hcount neither stepped nor wrapped");
            step_bad = 1'b1;
        end

endmodule

bind vga_top vga_top_chk i_vga_top_chk (
    .clk    (clk),
    .rst    (rst),
    .hcount (hcount),
    .hsync  (hsync),
    .vsync  (vsync),
    .hblnk  (hblnk),
    .vblnk  (vblnk)
);

/* testbench/vga_top_tb.sv */
`timescale 1ns/10ps

module vga_top_tb
    import vga_pkg::*;
();

    // same values as the DUT parameter defaults
    localparam int TOP_V_LINE    = 317;
    localparam int BOTTOM_V_LINE = 617;
    localparam int LEFT_H_LINE   = 361;
    localparam int RIGHT_H_LINE  = 661;
    localparam int BORDER        = 10;

    localparam int HS_START       = H_ACTIVE + H_FP;
    localparam int HS_END         = H_ACTIVE + H_FP + H_SYNC;
    localparam int VS_START       = V_ACTIVE + V_FP;
    localparam int VS_END         = V_ACTIVE + V_FP + V_SYNC;
    localparam int RUN_CYCLES     = 2 * H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 2_200_000;
    localparam int MODE_PERIOD    = 4096;
    // mid-line move, takes effect in the middle of the play field
    localparam int MARKER_MOVE    = 512;

    localparam logic [31:0] LFSR_SEED = 32'h9d57_14ec;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        rst;
    mode_t       control_state;
    logic [11:0] marker_x;
    logic [11:0] marker_y;
    logic [11:0] hcount;
    logic [11:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;

    // reference model state
    logic [31:0] lfsr_state;
    int          exp_h;
    int          exp_v;
    rgb_t        bg_colour;
    mode_t       mode_d1;
    mode_t       mode_d2;
    logic [11:0] mx_d1;
    logic [11:0] my_d1;
    int          cycle_count = 0;

    vga_top i_vga_top (
        .clk           (clk),
        .rst           (rst),
        .control_state (control_state),
        .marker_x      (marker_x),
        .marker_y      (marker_y),
        .hcount        (hcount),
        .vcount        (vcount),
        .hsync         (hsync),
        .vsync         (vsync),
        .hblnk         (hblnk),
        .vblnk         (vblnk),
        .rgb           (rgb)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit
    function automatic logic [11:0] random_bits(int count);
        logic [11:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[10:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic int clamp(int value, int lo, int hi);
        if (value < lo) begin
            return lo;
        end
        if (value > hi) begin
            return hi;
        end
        return value;
    endfunction

    function automatic rgb_t background_colour(mode_t mode, int h, int v, rgb_t held);
        logic blank;
        logic title;
        logic outer;
        logic inner;
        rgb_t colour;
        blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);
        title = (h >= TITLE_X0) && (h <= TITLE_X1) && (v >= TITLE_Y0) && (v <= TITLE_Y1);
        outer = (h >= LEFT_H_LINE - BORDER) && (h < RIGHT_H_LINE + BORDER) &&
                (v >= TOP_V_LINE - BORDER) && (v < BOTTOM_V_LINE + BORDER);
        inner = (h >= LEFT_H_LINE) && (h < RIGHT_H_LINE) &&
                (v >= TOP_V_LINE) && (v < BOTTOM_V_LINE);
        case (mode)
            VICTORY_MODE: colour = C_VICTORY;
            GAME_OVER:    colour = C_GAME_OVER;
            MULTI_WAIT:   colour = C_WAIT;
            MENU_MODE, GAME_MODE: begin
                if (blank) begin
                    colour = C_BLACK;
                end else if (v == 0) begin
                    colour = C_YELLOW;
                end else if (v == V_ACTIVE - 1) begin
                    colour = C_RED;
                end else if (h == 0) begin
                    colour = C_GREEN;
                end else if (h == H_ACTIVE - 1) begin
                    colour = C_BLUE;
                end else if (mode == MENU_MODE && title) begin
                    colour = C_WHITE;
                end else if (mode == GAME_MODE && outer && !inner) begin
                    colour = C_WHITE;
                end else begin
                    colour = C_BLACK;
                end
            end
            default: colour = held;
        endcase
        return colour;
    endfunction

    function automatic rgb_t marker_overlay(rgb_t under, mode_t mode, int h, int v,
                                            int mx, int my);
        int x;
        int y;
        x = clamp(mx, LEFT_H_LINE, RIGHT_H_LINE - MARKER_SIZE);
        y = clamp(my, TOP_V_LINE, BOTTOM_V_LINE - MARKER_SIZE);
        if (mode == GAME_MODE && h < H_ACTIVE && v < V_ACTIVE &&
            h >= x && h < x + MARKER_SIZE && v >= y && v < y + MARKER_SIZE) begin
            return C_MARKER;
        end
        return under;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got == expected) else begin
            $display("Fail %s: got %0h, expected %0h", name, got, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_reset_state();
        check_value("hcount", 32'(hcount), 32'd0);
        check_value("vcount", 32'(vcount), 32'd0);
        check_value("hsync", 32'(hsync), 32'd0);
        check_value("vsync", 32'(vsync), 32'd0);
        check_value("hblnk", 32'(hblnk), 32'd0);
        check_value("vblnk", 32'(vblnk), 32'd0);
        check_value("rgb", 32'(rgb), 32'd0);
    endtask

    // k counts edges since reset release
    // pixel 0 fills the pipe for two of them
    task automatic check_pixel(int k);
        rgb_t want;
        check_value("hcount", 32'(hcount), 32'(exp_h));
        check_value("vcount", 32'(vcount), 32'(exp_v));
        check_value("hblnk", 32'(hblnk), 32'(exp_h >= H_ACTIVE));
        check_value("vblnk", 32'(vblnk), 32'(exp_v >= V_ACTIVE));
        check_value("hsync", 32'(hsync), 32'(exp_h >= HS_START && exp_h < HS_END));
        check_value("vsync", 32'(vsync), 32'(exp_v >= VS_START && exp_v < VS_END));
        if (k >= 2) begin
            bg_colour = background_colour(mode_d2, exp_h, exp_v, bg_colour);
            want = marker_overlay(bg_colour, mode_d1, exp_h, exp_v, int'(mx_d1), int'(my_d1));
            check_value("rgb", 32'(rgb), 32'(want));
            exp_h = exp_h + 1;
            if (exp_h == H_TOTAL) begin
                exp_h = 0;
                exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
            end
        end
        assert (!i_vga_top.i_vga_top_chk.failed) else begin
            $display("a bound assertion on the raster outputs failed");
            $display("Test FAILED");
            $fatal(1, "bound assertion");
        end
    endtask

    task automatic drive_inputs(int k);
        logic [11:0] bits;
        if (k % MODE_PERIOD == 0) begin
            bits = random_bits(3);
            control_state = mode_t'(bits[2:0]);
        end
        if (k % H_TOTAL == 0 || k % H_TOTAL == MARKER_MOVE) begin
            bits = random_bits(11);
            marker_x = {1'b0, bits[10:0]};
            bits = random_bits(11);
            marker_y = {1'b0, bits[10:0]};
        end
    endtask

    initial begin
        rst = 1'b1;
        control_state = MENU_MODE;
        marker_x = '0;
        marker_y = '0;
        lfsr_state = LFSR_SEED;
        exp_h = 0;
        exp_v = 0;
        bg_colour = C_BLACK;
        mode_d1 = MENU_MODE;
        mode_d2 = MENU_MODE;
        mx_d1 = '0;
        my_d1 = '0;
        repeat (2) @(posedge clk);
        #1;
        check_reset_state();
        rst = 1'b0;
        drive_inputs(0);
        for (int k = 1; k <= RUN_CYCLES; k++) begin
            @(posedge clk);
            #1;
            // inputs seen by the DUT at this edge and the one before
            mode_d2 = mode_d1;
            mode_d1 = control_state;
            mx_d1 = marker_x;
            my_d1 = marker_y;
            check_pixel(k);
            drive_inputs(k);
        end
        if (i_vga_top.i_vga_top_chk.failed) begin
            $display("a bound assertion on the raster outputs failed");
            $display("Test FAILED");
            $fatal(1, "bound assertion");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* vlog.f */
src/vga_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/draw_background.sv
src/draw_marker.sv
src/vga_top.sv
testbench/vga_top_chk.sv
testbench/vga_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the vga_top testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert -f vlog.f --top-module vga_top_tb -o vga_top_tb_sim \
    && ./obj_dir/vga_top_tb_sim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
